//--- design/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

////////////////////
// data path widths
////////////////////

// core data word
`define DC_XLEN 32

// physical address
`define DC_PLEN 32

// one cache line holds two words
`define DC_BLK_BITS 64

////////////////////
// cache geometry
////////////////////

`define DC_WAYS 2

// 16 sets
`define DC_IDX_BITS 4

// byte offset within a line
`define DC_BLK_OFFS_BITS 3

// word select within a line
`define DC_DAT_OFFS_BITS 1

// whatever is left above index and offset
`define DC_TAG_BITS 25

// idle cycles after a fill so the tag and data memories can settle
`define DC_RECOVER_CYCLES 2

`endif

//--- design/dcache_pkg.sv
`include "dcache_config.svh"

package dcache_pkg;

  ////////////////////
  // basic words
  ////////////////////

  typedef logic [`DC_XLEN-1:0]       word_t;
  typedef logic [`DC_BLK_BITS-1:0]   line_t;
  typedef logic [`DC_XLEN/8-1:0]     be_t;
  typedef logic [`DC_BLK_BITS/8-1:0] line_be_t;
  typedef logic [`DC_WAYS-1:0]       ways_t;
  typedef logic [`DC_IDX_BITS-1:0]   idx_t;
  typedef logic [`DC_TAG_BITS-1:0]   tag_t;
  typedef logic [`DC_DAT_OFFS_BITS-1:0] offs_t;

  ////////////////////
  // address decode
  ////////////////////

  // tag | index | word in line | byte in word
  typedef struct packed {
    tag_t                                               tag;
    idx_t                                               idx;
    offs_t                                              offs;
    logic [`DC_BLK_OFFS_BITS-`DC_DAT_OFFS_BITS-1:0]     lane;
  } adr_fields_t;

  typedef union packed {
    logic [`DC_PLEN-1:0] raw;
    adr_fields_t         f;
  } adr_u;

  // miss controller
  typedef enum logic [2:0] {
    ARMED,
    FILL_REQ,
    FILL_REL,
    RECOVER0,
    RECOVER1
  } miss_state_e;

endpackage

//--- design/dcache_hit_path.sv
`timescale 1ns/10ps
`include "dcache_config.svh"

module dcache_hit_path
  import dcache_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,

  input  logic     req_i,
  input  logic     we_i,
  input  adr_u     adr_i,
  input  be_t      be_i,
  input  word_t    d_i,
  input  logic     access_fault_i,
  input  logic     misaligned_i,
  input  logic     pagefault_i,

  input  logic     cache_hit_i,
  input  ways_t    ways_hit_i,
  input  line_t    cache_line_i,
  output idx_t     idx_o,
  output tag_t     tag_o,

  input  logic     armed_i,
  output logic     valid_o,
  output logic     miss_o,
  output logic     hit_ack_o,
  output word_t    hit_q_o,
  output logic     wb_stall_o,

  output logic     wb_we_o,
  input  logic     wb_ack_i,
  output idx_t     wb_idx_o,
  output offs_t    wb_offs_o,
  output word_t    wb_data_o,
  output line_be_t wb_be_o,
  output ways_t    wb_ways_o
);

  logic  wb_busy;
  logic  rd_hit;
  logic  wr_hit;
  logic  bypass;
  offs_t dat_offs;
  line_t merged_line;

  ////////////////////
  // qualification
  ////////////////////

  assign valid_o  = req_i & ~access_fault_i & ~misaligned_i & ~pagefault_i;
  assign miss_o   = valid_o & ~cache_hit_i;

  assign idx_o    = adr_i.f.idx;
  assign tag_o    = adr_i.f.tag;
  assign dat_offs = adr_i.f.offs;

  // buffer is busy until the four-phase cycle has fully returned to idle
  assign wb_busy    = wb_we_o | wb_ack_i;

  assign rd_hit     = armed_i & valid_o & cache_hit_i & ~we_i;
  assign wr_hit     = armed_i & valid_o & cache_hit_i & we_i & ~wb_busy;
  assign wb_stall_o = armed_i & valid_o & cache_hit_i & we_i & wb_busy;

  assign hit_ack_o  = rd_hit | wr_hit;

  ////////////////////
  // write buffer
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_we_o <= 1'b0;
    end else if (wr_hit) begin
      wb_we_o <= 1'b1;
    end else if (wb_ack_i) begin
      wb_we_o <= 1'b0;
    end
  end

  // byte enables land at the word position inside the line
  always_ff @(posedge clk_i) begin
    if (wr_hit) begin
      wb_idx_o  <= adr_i.f.idx;
      wb_offs_o <= dat_offs;
      wb_data_o <= d_i;
      wb_be_o   <= line_be_t'(be_i) << (dat_offs * (`DC_XLEN / 8));
      wb_ways_o <= ways_hit_i;
    end
  end

  ////////////////////
  // read bypass
  ////////////////////

  // same set and way as the pending write
  assign bypass = wb_we_o & (adr_i.f.idx == wb_idx_o) & (ways_hit_i == wb_ways_o);

  always_comb begin
    line_t wb_line;
    wb_line = {(`DC_BLK_BITS / `DC_XLEN){wb_data_o}};
    for (int i = 0; i < `DC_BLK_BITS / 8; i++) begin
      merged_line[i*8 +: 8] = (bypass && wb_be_o[i]) ? wb_line[i*8 +: 8]
                                                      : cache_line_i[i*8 +: 8];
    end
  end

  assign hit_q_o = merged_line[dat_offs * `DC_XLEN +: `DC_XLEN];

  // pending entry must not move under the buffer
  a_wb_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    wb_we_o && !wb_ack_i |=> wb_we_o &&
      $stable({wb_idx_o, wb_offs_o, wb_data_o, wb_be_o, wb_ways_o})
  );

endmodule

//--- design/dcache_miss_ctrl.sv
`timescale 1ns/10ps
`include "dcache_config.svh"

module dcache_miss_ctrl
  import dcache_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,

  input  logic  miss_i,
  input  adr_u  adr_i,
  input  ways_t ways_hit_i,
  input  ways_t fill_way_i,

  output logic  armed_o,
  output logic  miss_stall_o,

  output logic  fill_req_o,
  input  logic  fill_ack_i,
  output idx_t  fill_idx_o,
  output tag_t  fill_tag_o,
  output ways_t fill_way_o,
  output logic  filling_o,

  input  logic  fill_err_i,
  input  word_t fill_q_i,
  output logic  fill_done_o,
  output logic  fill_err_o,
  output word_t fill_q_o
);

  miss_state_e state;
  miss_state_e nxt_state;
  logic        fill_ack_seen;

  ////////////////////
  // state machine
  ////////////////////

  always_comb begin
    nxt_state    = state;
    miss_stall_o = 1'b1;

    case (state)
      ARMED: begin
        miss_stall_o = miss_i;
        if (miss_i) begin
          nxt_state = FILL_REQ;
        end
      end

      // requested word is returned with the ack, core takes it here
      FILL_REQ: begin
        miss_stall_o = ~fill_ack_i;
        if (fill_ack_i) begin
          nxt_state = FILL_REL;
        end
      end

      // wait for the BIU to drop its ack
      FILL_REL: begin
        if (!fill_ack_i) begin
          nxt_state = RECOVER0;
        end
      end

      // set up index for tag and data memories
      RECOVER0: nxt_state = RECOVER1;

      // memory outputs valid again
      RECOVER1: nxt_state = ARMED;

      default: nxt_state = ARMED;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state <= ARMED;
    end else begin
      state <= nxt_state;
    end
  end

  assign armed_o    = (state == ARMED);
  assign fill_req_o = (state == FILL_REQ);
  assign filling_o  = (state == FILL_REQ) || (state == FILL_REL);

  ////////////////////
  // fill address
  ////////////////////

  // a way holding a matching but invalid tag is reused, else take the victim
  always_ff @(posedge clk_i) begin
    if (armed_o && miss_i) begin
      fill_idx_o <= adr_i.f.idx;
      fill_tag_o <= adr_i.f.tag;
      fill_way_o <= (|ways_hit_i) ? ways_hit_i : fill_way_i;
    end
  end

  // fill result is registered once in the response unit
  assign fill_ack_seen = (state == FILL_REQ) & fill_ack_i;
  assign fill_done_o   = fill_ack_seen & ~fill_err_i;
  assign fill_err_o    = fill_ack_seen & fill_err_i;
  assign fill_q_o      = fill_q_i;

  ////////////////////
  // checks
  ////////////////////

  a_req_held : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $fell(fill_req_o) |-> $past(fill_ack_i)
  );

  a_state_legal : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    state inside {ARMED, FILL_REQ, FILL_REL, RECOVER0, RECOVER1}
  );

endmodule

//--- design/dcache_resp.sv
`timescale 1ns/10ps
`include "dcache_config.svh"

module dcache_resp
  import dcache_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,

  input  logic  valid_i,
  input  logic  req_i,
  input  logic  access_fault_i,
  input  logic  misaligned_i,
  input  logic  pagefault_i,

  // hit side
  input  logic  hit_ack_i,
  input  word_t hit_q_i,
  input  logic  wb_stall_i,

  // miss side
  input  logic  miss_stall_i,
  input  logic  fill_done_i,
  input  logic  fill_err_i,
  input  word_t fill_q_i,

  output logic  ack_o,
  output word_t q_o,
  output logic  err_o,
  output logic  misaligned_o,
  output logic  pagefault_o,
  output logic  stall_o
);

  logic consumed;
  logic done;

  assign stall_o  = wb_stall_i | miss_stall_i;
  assign consumed = req_i & ~stall_o;

  // only a request taken this cycle can complete
  assign done     = valid_i & ~stall_o & (hit_ack_i | fill_done_i);

  ////////////////////
  // core response
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_o        <= 1'b0;
      err_o        <= 1'b0;
      misaligned_o <= 1'b0;
      pagefault_o  <= 1'b0;
    end else begin
      ack_o        <= done;
      err_o        <= fill_err_i | (consumed & access_fault_i);
      misaligned_o <= consumed & misaligned_i;
      pagefault_o  <= consumed & pagefault_i;
    end
  end

  // read data from whichever side finished
  always_ff @(posedge clk_i) begin
    if (hit_ack_i) begin
      q_o <= hit_q_i;
    end else if (fill_done_i) begin
      q_o <= fill_q_i;
    end
  end

  a_ack_err_excl : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(ack_o && err_o)
  );

endmodule

//--- design/dcache_hit_stage.sv
`timescale 1ns/10ps
`include "dcache_config.svh"

module dcache_hit_stage
  import dcache_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,

  // core
  input  logic                req_i,
  input  logic                we_i,
  input  logic [`DC_PLEN-1:0] adr_i,
  input  be_t                 be_i,
  input  word_t               d_i,
  input  logic                access_fault_i,
  input  logic                misaligned_i,
  input  logic                pagefault_i,
  output logic                ack_o,
  output word_t               q_o,
  output logic                err_o,
  output logic                misaligned_o,
  output logic                pagefault_o,
  output logic                stall_o,

  // tag and data memories
  input  logic                cache_hit_i,
  input  ways_t               ways_hit_i,
  input  line_t               cache_line_i,
  input  ways_t               fill_way_i,
  output idx_t                idx_o,
  output tag_t                tag_o,

  // write buffer
  output logic                wb_we_o,
  input  logic                wb_ack_i,
  output idx_t                wb_idx_o,
  output offs_t               wb_offs_o,
  output word_t               wb_data_o,
  output line_be_t            wb_be_o,
  output ways_t               wb_ways_o,

  // line fill
  output logic                fill_req_o,
  input  logic                fill_ack_i,
  output idx_t                fill_idx_o,
  output tag_t                fill_tag_o,
  output ways_t               fill_way_o,
  input  word_t               fill_q_i,
  input  logic                fill_err_i,
  output logic                filling_o
);

  adr_u  core_adr;
  logic  valid;
  logic  miss;
  logic  armed;
  logic  hit_ack;
  word_t hit_q;
  logic  wb_stall;
  logic  miss_stall;
  logic  fill_done;
  logic  fill_err;
  word_t fill_q;

  // flat core address, decoded into fields below
  assign core_adr.raw = adr_i;

  dcache_hit_path u_hit_path (
    .clk_i, .rst_ni, .req_i, .we_i,
    .adr_i (core_adr), .be_i, .d_i,
    .access_fault_i, .misaligned_i, .pagefault_i,
    .cache_hit_i, .ways_hit_i, .cache_line_i, .idx_o, .tag_o,
    .armed_i (armed), .valid_o (valid), .miss_o (miss),
    .hit_ack_o (hit_ack), .hit_q_o (hit_q), .wb_stall_o (wb_stall),
    .wb_we_o, .wb_ack_i, .wb_idx_o, .wb_offs_o, .wb_data_o, .wb_be_o, .wb_ways_o
  );

  dcache_miss_ctrl u_miss_ctrl (
    .clk_i, .rst_ni, .miss_i (miss), .adr_i (core_adr),
    .ways_hit_i, .fill_way_i, .armed_o (armed), .miss_stall_o (miss_stall),
    .fill_req_o, .fill_ack_i, .fill_idx_o, .fill_tag_o, .fill_way_o, .filling_o,
    .fill_err_i, .fill_q_i,
    .fill_done_o (fill_done), .fill_err_o (fill_err), .fill_q_o (fill_q)
  );

  dcache_resp u_resp (
    .clk_i, .rst_ni, .valid_i (valid), .req_i,
    .access_fault_i, .misaligned_i, .pagefault_i,
    .hit_ack_i (hit_ack), .hit_q_i (hit_q), .wb_stall_i (wb_stall),
    .miss_stall_i (miss_stall), .fill_done_i (fill_done),
    .fill_err_i (fill_err), .fill_q_i (fill_q),
    .ack_o, .q_o, .err_o, .misaligned_o, .pagefault_o, .stall_o
  );

endmodule

//--- testbench/dcache_tb_model.svh
`ifndef DCACHE_TB_MODEL_SVH
`define DCACHE_TB_MODEL_SVH

////////////////////
// reference model
////////////////////

// data memory contents per set and way
line_t phys_mem [2**`DC_IDX_BITS][`DC_WAYS];

// write held by the buffer, not yet in the data memory
logic  pend_valid;
idx_t  pend_idx;
int    pend_way;
offs_t pend_offs;
word_t pend_data;
be_t   pend_be;

// responder controls
int    wb_wait;
int    fill_wait;
logic  fill_err_next;
word_t fill_word;

int    errors;
logic  test_bad;
string test_name;

// put the enabled bytes of one word into its slot of the line
function automatic line_t merge_write(line_t l, offs_t o, word_t d, be_t be);
  int base;
  base = o * (`DC_XLEN / 8);
  for (int b = 0; b < `DC_XLEN / 8; b++) begin
    if (be[b]) begin
      l[(base + b) * 8 +: 8] = d[b * 8 +: 8];
    end
  end
  return l;
endfunction

// what the core must see, pending write included
function automatic word_t read_word(adr_u a, int way);
  line_t l;
  l = phys_mem[a.f.idx][way];
  if (pend_valid && pend_idx == a.f.idx && pend_way == way) begin
    l = merge_write(l, pend_offs, pend_data, pend_be);
  end
  return l[a.f.offs * `DC_XLEN +: `DC_XLEN];
endfunction

////////////////////
// compare tasks
////////////////////

task automatic check_word(string what, word_t exp, word_t act);
  if (exp !== act) begin
    $display("** Error %s: %s expected %h actual %h", test_name, what, exp, act);
    errors++;
    test_bad = 1'b1;
  end
endtask

task automatic check_be(string what, line_be_t exp, line_be_t act);
  if (exp !== act) begin
    $display("** Error %s: %s expected %b actual %b", test_name, what, exp, act);
    errors++;
    test_bad = 1'b1;
  end
endtask

task automatic check_bit(string what, logic exp, logic act);
  if (exp !== act) begin
    $display("** Error %s: %s expected %b actual %b", test_name, what, exp, act);
    errors++;
    test_bad = 1'b1;
  end
endtask

////////////////////
// responders
////////////////////

// one falling edge worth of write buffer and BIU behavior
task automatic run_responders();
  if (wb_ack_i && !wb_we_o) begin
    // four-phase done, the write lands in the data memory
    wb_ack_i = 1'b0;
    phys_mem[pend_idx][pend_way] =
      merge_write(phys_mem[pend_idx][pend_way], pend_offs, pend_data, pend_be);
    pend_valid = 1'b0;
  end else if (wb_we_o && !wb_ack_i) begin
    if (wb_wait == 0) begin
      wb_ack_i = 1'b1;
    end else begin
      wb_wait--;
    end
  end

  if (fill_ack_i && !fill_req_o) begin
    fill_ack_i = 1'b0;
    fill_err_i = 1'b0;
  end else if (fill_req_o && !fill_ack_i) begin
    if (fill_wait == 0) begin
      fill_ack_i = 1'b1;
      fill_q_i   = fill_word;
      fill_err_i = fill_err_next;
    end else begin
      fill_wait--;
    end
  end
endtask

`endif

//--- testbench/tb_dcache_hit_stage.sv
`timescale 1ns/10ps
`include "dcache_config.svh"

module tb_dcache_hit_stage
  import dcache_pkg::*;
();

  localparam int WAIT_LIMIT = 100;

  logic                clk_i;
  logic                rst_ni;
  logic                req_i, we_i, access_fault_i, misaligned_i, pagefault_i;
  logic [`DC_PLEN-1:0] adr_i;
  be_t                 be_i;
  word_t               d_i, q_o, wb_data_o, fill_q_i;
  logic                ack_o, err_o, misaligned_o, pagefault_o, stall_o;
  logic                cache_hit_i, wb_we_o, wb_ack_i;
  ways_t               ways_hit_i, fill_way_i, wb_ways_o, fill_way_o;
  line_t               cache_line_i;
  idx_t                idx_o, wb_idx_o, fill_idx_o;
  tag_t                tag_o, fill_tag_o;
  offs_t               wb_offs_o;
  line_be_t            wb_be_o;
  logic                fill_req_o, fill_ack_i, fill_err_i, filling_o;

  integer seed;
  int     tests;
  int     failed;
  int     kind;
  logic   stall_seen;
  adr_u   cur_adr;
  int     cur_way;
  be_t    cur_be;
  word_t  cur_d;

  `include "dcache_tb_model.svh"

  dcache_hit_stage DUT (
    .clk_i, .rst_ni, .req_i, .we_i, .adr_i, .be_i, .d_i,
    .access_fault_i, .misaligned_i, .pagefault_i,
    .ack_o, .q_o, .err_o, .misaligned_o, .pagefault_o, .stall_o,
    .cache_hit_i, .ways_hit_i, .cache_line_i, .fill_way_i, .idx_o, .tag_o,
    .wb_we_o, .wb_ack_i, .wb_idx_o, .wb_offs_o, .wb_data_o, .wb_be_o, .wb_ways_o,
    .fill_req_o, .fill_ack_i, .fill_idx_o, .fill_tag_o, .fill_way_o,
    .fill_q_i, .fill_err_i, .filling_o
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic end_run();
    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(string what);
    $display("%s: timed out waiting for %s", test_name, what);
    errors++;
    end_run();
  endtask

  // outputs are sampled before anything is driven on this edge
  task automatic next_cycle();
    @(negedge clk_i);
    stall_seen = stall_o;
    run_responders();
  endtask

  task automatic roll_request();
    cur_adr.raw = $random(seed);
    cur_way     = $unsigned($random(seed)) % `DC_WAYS;
    cur_be      = $random(seed);
    cur_d       = $random(seed);
  endtask

  task automatic present(logic we, logic hit, logic [2:0] flt);
    req_i        = 1'b1;
    we_i         = we;
    adr_i        = cur_adr.raw;
    be_i         = cur_be;
    d_i          = cur_d;
    {access_fault_i, misaligned_i, pagefault_i} = flt;
    cache_hit_i  = hit;
    ways_hit_i   = hit ? ways_t'(1 << cur_way) : '0;
    cache_line_i = phys_mem[cur_adr.f.idx][cur_way];
    fill_way_i   = ways_t'(1 << ($unsigned($random(seed)) % `DC_WAYS));
  endtask

  // pend_before tells whether a write was pending at the consuming edge
  task automatic wait_response(output int cycles, output logic pend_before);
    cycles      = 0;
    pend_before = pend_valid;
    next_cycle();
    // memory index and tag follow the held address
    check_word("memory index", cur_adr.raw[`DC_BLK_OFFS_BITS +: `DC_IDX_BITS], idx_o);
    check_word("memory tag", cur_adr.raw[`DC_PLEN-1 -: `DC_TAG_BITS], tag_o);
    while (!(ack_o || err_o || misaligned_o || pagefault_o)) begin
      cycles++;
      if (cycles > WAIT_LIMIT) abort_on_timeout("a response to the core");
      pend_before = pend_valid;
      next_cycle();
    end
    req_i = 1'b0;
  endtask

  task automatic wait_wb_idle();
    int n;
    n = 0;
    while (wb_we_o || wb_ack_i || pend_valid) begin
      n++;
      if (n > WAIT_LIMIT) abort_on_timeout("the write buffer to drain");
      next_cycle();
    end
  endtask

  task automatic do_read();
    int    cyc;
    logic  pb;
    word_t exp;
    exp = read_word(cur_adr, cur_way);
    present(1'b0, 1'b1, 3'b000);
    wait_response(cyc, pb);
    check_bit("ack one cycle after request", 1'b1, cyc == 0);
    check_bit("ack", 1'b1, ack_o);
    check_word("read data", exp, q_o);
  endtask

  task automatic do_write(int hold, logic expect_stall);
    int       cyc;
    logic     pb;
    line_be_t exp_be;
    exp_be  = cur_adr.f.offs ? {cur_be, be_t'(0)} : {be_t'(0), cur_be};
    wb_wait = hold;
    present(1'b1, 1'b1, 3'b000);
    wait_response(cyc, pb);
    if (expect_stall) begin
      check_bit("held by busy buffer", 1'b1, cyc > 0);
      check_bit("earlier write pending at capture", 1'b0, pb);
    end
    check_bit("ack", 1'b1, ack_o);
    check_bit("wb_we", 1'b1, wb_we_o);
    check_word("wb index", cur_adr.f.idx, wb_idx_o);
    check_word("wb offset", cur_adr.f.offs, wb_offs_o);
    check_word("wb data", cur_d, wb_data_o);
    check_be("wb byte enables", exp_be, wb_be_o);
    check_word("wb ways", ways_t'(1 << cur_way), wb_ways_o);
    pend_valid = 1'b1;
    pend_idx   = cur_adr.f.idx;
    pend_way   = cur_way;
    pend_offs  = cur_adr.f.offs;
    pend_data  = cur_d;
    pend_be    = cur_be;
  endtask

  task automatic do_miss();
    int   cyc;
    int   n;
    int   ack_delay;
    logic pb;
    fill_wait     = $unsigned($random(seed)) % 4;
    ack_delay     = fill_wait;
    fill_word     = $random(seed);
    fill_err_next = ($random(seed) & 3) == 0;
    if (fill_err_next) test_name = "fill_error";
    present(1'b0, 1'b0, 3'b000);
    n = 0;
    while (!fill_req_o) begin
      n++;
      if (n > WAIT_LIMIT) abort_on_timeout("the fill request");
      next_cycle();
    end
    check_bit("stall during fill", 1'b1, stall_seen);
    check_bit("filling", 1'b1, filling_o);
    check_word("fill index", cur_adr.f.idx, fill_idx_o);
    check_word("fill tag", cur_adr.f.tag, fill_tag_o);
    check_word("fill way", fill_way_i, fill_way_o);
    wait_response(cyc, pb);
    // fill ack is raised ack_delay edges after the request is seen
    check_word("cycles from fill ack to response", ack_delay, cyc);
    check_bit("ack", ~fill_err_next, ack_o);
    check_bit("err", fill_err_next, err_o);
    if (!fill_err_next) check_word("fill data", fill_word, q_o);
    // release wait plus recovery
    n = 0;
    while (stall_seen) begin
      n++;
      if (n > WAIT_LIMIT) abort_on_timeout("the end of recovery");
      next_cycle();
    end
    check_word("stall cycles after fill", `DC_RECOVER_CYCLES + 1, n);
    check_bit("filling after recovery", 1'b0, filling_o);
  endtask

  task automatic do_fault();
    int         cyc;
    logic       pb;
    logic [2:0] flt;
    flt = 3'b001 << ($unsigned($random(seed)) % 3);
    wait_wb_idle();
    present($random(seed), $random(seed), flt);
    wait_response(cyc, pb);
    check_bit("access fault", flt[2], err_o);
    check_bit("misaligned", flt[1], misaligned_o);
    check_bit("page fault", flt[0], pagefault_o);
    check_bit("ack", 1'b0, ack_o);
    check_bit("fill request", 1'b0, fill_req_o);
    check_bit("wb_we", 1'b0, wb_we_o);
  endtask

  initial begin
    seed   = 32'hccedc6e4;
    errors = 0;
    tests  = 0;
    failed = 0;
    rst_ni = 1'b0;
    {req_i, we_i, access_fault_i, misaligned_i, pagefault_i} = '0;
    {adr_i, be_i, d_i, cache_hit_i, ways_hit_i, cache_line_i, fill_way_i} = '0;
    {wb_ack_i, fill_ack_i, fill_q_i, fill_err_i} = '0;
    {pend_valid, wb_wait, fill_wait, fill_err_next, fill_word} = '0;
    for (int s = 0; s < 2**`DC_IDX_BITS; s++) begin
      for (int w = 0; w < `DC_WAYS; w++) begin
        phys_mem[s][w] = {$random(seed), $random(seed)};
      end
    end
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;

    test_name = "reset";
    test_bad  = 1'b0;
    next_cycle();
    check_bit("ack", 1'b0, ack_o);
    check_bit("err", 1'b0, err_o | misaligned_o | pagefault_o);
    check_bit("wb_we", 1'b0, wb_we_o);
    check_bit("fill request", 1'b0, fill_req_o | filling_o);
    check_bit("stall", 1'b0, stall_o);
    tests++;
    failed += test_bad;
    $display("test %0d %s %s", tests, test_name, test_bad ? "mismatch" : "ok");

    for (int n = 0; n < 60; n++) begin
      test_bad = 1'b0;
      kind     = $unsigned($random(seed)) % 6;
      roll_request();
      case (kind)
        0: begin
          test_name = "read_hit";
          do_read();
        end
        1: begin
          test_name = "write_hit";
          do_write($unsigned($random(seed)) % 4, 1'b0);
        end
        2: begin
          test_name = "write_backpressure";
          wait_wb_idle();
          do_write(3, 1'b0);
          roll_request();
          do_write(2, 1'b1);
        end
        3: begin
          // same set, way and word as the write still in the buffer
          test_name = "bypass";
          wait_wb_idle();
          do_write(4, 1'b0);
          do_read();
        end
        4: begin
          test_name = "miss";
          do_miss();
        end
        default: begin
          test_name = "fault";
          do_fault();
        end
      endcase
      tests++;
      failed += test_bad;
      $display("test %0d %s %s", tests, test_name, test_bad ? "mismatch" : "ok");
    end
    end_run();
  end

endmodule

//--- src.f
+incdir+design
+incdir+testbench
design/dcache_pkg.sv
design/dcache_hit_path.sv
design/dcache_miss_ctrl.sv
design/dcache_resp.sv
design/dcache_hit_stage.sv
testbench/tb_dcache_hit_stage.sv

//--- Bender.yml
package:
  name: dcache_hit_stage

export_include_dirs:
  - design

sources:
  - design/dcache_pkg.sv
  - design/dcache_hit_path.sv
  - design/dcache_miss_ctrl.sv
  - design/dcache_resp.sv
  - design/dcache_hit_stage.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_dcache_hit_stage.sv
